// File: verilog/cpu_pkg.sv
package cpu_pkg;

        // datapath width and register file geometry
        localparam int xlen       = 16;
        localparam int reg_count  = 16;
        localparam int reg_addr_w = 4;

        // immediate widths, imm4 is the low nibble of the imm8 field
        localparam int imm8_w = 8;
        localparam int imm4_w = 4;

        // instructions are two bytes apart
        localparam logic [xlen-1:0] pc_step = 16'd2;

        // instruction word layout
        localparam int op_hi   = 15;
        localparam int op_lo   = 12;
        localparam int rd_hi   = 11;
        localparam int rd_lo   = 8;
        localparam int rs1_hi  = 7;
        localparam int rs1_lo  = 4;
        localparam int rs2_hi  = 3;
        localparam int rs2_lo  = 0;
        localparam int imm8_hi = 7;
        localparam int imm8_lo = 0;

        // opcodes, 7 and 13..15 are unused and run as nop
        typedef enum logic [3:0] {
                op_add  = 4'd0,
                op_grt  = 4'd1,
                op_sub  = 4'd2,
                op_eq   = 4'd3,
                op_jalr = 4'd4,
                op_lui  = 4'd5,
                op_jal  = 4'd6,
                op_addi = 4'd8,
                op_lw   = 4'd9,
                op_sw   = 4'd10,
                op_bne  = 4'd11,
                op_wri  = 4'd12
        } opcode_t;

        typedef enum logic [2:0] {alu_add, alu_sub, alu_gt, alu_eq, alu_lui} alu_op_t;

        // read port b address source
        typedef enum logic {b_rs2, b_rd} b_sel_t;

        // register writeback source
        typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_t;

        typedef enum logic [1:0] {pc_seq, pc_jal, pc_jalr, pc_bne} pc_sel_t;

endpackage

// File: verilog/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;

        cpu_pkg::alu_op_t alu_op;
        // 1 picks sign extended imm4, 0 picks read port b
        logic             alu_src;
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        // wri request on the output port
        logic             out_write;
        cpu_pkg::b_sel_t  b_sel;
        cpu_pkg::wb_sel_t wb_sel;
        cpu_pkg::pc_sel_t pc_sel;

        // decoder is the only driver
        modport decoder (
                output alu_op, alu_src, reg_write, mem_read, mem_write,
                       out_write, b_sel, wb_sel, pc_sel
        );

        // datapath blocks only look at the controls
        modport user (
                input alu_op, alu_src, reg_write, mem_read, mem_write,
                      out_write, b_sel, wb_sel, pc_sel
        );

endinterface

// File: verilog/control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
        input  cpu_pkg::opcode_t op,
        ctrl_if.decoder          ctrl
);

        always_comb begin
                // nop defaults, every write off and pc steps by two
                ctrl.alu_op    = cpu_pkg::alu_add;
                ctrl.alu_src   = 1'b0;
                ctrl.reg_write = 1'b0;
                ctrl.mem_read  = 1'b0;
                ctrl.mem_write = 1'b0;
                ctrl.out_write = 1'b0;
                ctrl.b_sel     = cpu_pkg::b_rs2;
                ctrl.wb_sel    = cpu_pkg::wb_alu;
                ctrl.pc_sel    = cpu_pkg::pc_seq;

                case (op)
                        cpu_pkg::op_add: begin
                                // rd = rs1 + rs2
                                ctrl.reg_write = 1'b1;
                        end
                        cpu_pkg::op_sub: begin
                                ctrl.alu_op    = cpu_pkg::alu_sub;
                                ctrl.reg_write = 1'b1;
                        end
                        cpu_pkg::op_grt: begin
                                // unsigned rs1 > rs2 gives 1 or 0
                                ctrl.alu_op    = cpu_pkg::alu_gt;
                                ctrl.reg_write = 1'b1;
                        end
                        cpu_pkg::op_eq: begin
                                ctrl.alu_op    = cpu_pkg::alu_eq;
                                ctrl.reg_write = 1'b1;
                        end
                        cpu_pkg::op_jal: begin
                                // rd gets return address, pc jumps by imm8 words
                                ctrl.reg_write = 1'b1;
                                ctrl.wb_sel    = cpu_pkg::wb_link;
                                ctrl.pc_sel    = cpu_pkg::pc_jal;
                        end
                        cpu_pkg::op_jalr: begin
                                // target is rs1 + imm4, computed in the sequencer
                                ctrl.alu_src   = 1'b1;
                                ctrl.reg_write = 1'b1;
                                ctrl.wb_sel    = cpu_pkg::wb_link;
                                ctrl.pc_sel    = cpu_pkg::pc_jalr;
                        end
                        cpu_pkg::op_addi: begin
                                ctrl.alu_src   = 1'b1;
                                ctrl.reg_write = 1'b1;
                        end
                        cpu_pkg::op_lui: begin
                                // imm8 into the upper byte
                                ctrl.alu_op    = cpu_pkg::alu_lui;
                                ctrl.alu_src   = 1'b1;
                                ctrl.reg_write = 1'b1;
                        end
                        cpu_pkg::op_lw: begin
                                // address rs1 + imm4, data lands in rd
                                ctrl.alu_src   = 1'b1;
                                ctrl.reg_write = 1'b1;
                                ctrl.mem_read  = 1'b1;
                                ctrl.wb_sel    = cpu_pkg::wb_mem;
                        end
                        cpu_pkg::op_sw: begin
                                // store data comes from the rd field
                                ctrl.alu_src   = 1'b1;
                                ctrl.mem_write = 1'b1;
                                ctrl.b_sel     = cpu_pkg::b_rd;
                        end
                        cpu_pkg::op_bne: begin
                                // compare rs1 against rd
                                ctrl.b_sel  = cpu_pkg::b_rd;
                                ctrl.pc_sel = cpu_pkg::pc_bne;
                        end
                        cpu_pkg::op_wri: begin
                                // rd value goes out on the output port
                                ctrl.out_write = 1'b1;
                                ctrl.b_sel     = cpu_pkg::b_rd;
                        end
                        default: begin
                                // undecoded opcode keeps the nop defaults
                                ctrl.reg_write = 1'b0;
                        end
                endcase
        end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
        input  logic                           clk,
        input  logic                           rst_n,
        input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
        input  logic [cpu_pkg::reg_addr_w-1:0] rd_addr,
        // rs2 field, swapped for rd when b_sel asks
        input  logic [cpu_pkg::reg_addr_w-1:0] b_addr,
        // alu result
        input  logic [cpu_pkg::xlen-1:0]       wdata,
        input  logic [cpu_pkg::xlen-1:0]       mem_rdata,
        input  logic [cpu_pkg::xlen-1:0]       link,
        input  logic                           commit,
        output logic [cpu_pkg::xlen-1:0]       a_data,
        output logic [cpu_pkg::xlen-1:0]       b_data,
        ctrl_if.user                           ctrl
);

        logic [cpu_pkg::xlen-1:0]       regs [cpu_pkg::reg_count];
        logic [cpu_pkg::reg_addr_w-1:0] b_idx;
        logic [cpu_pkg::xlen-1:0]       wb_data;

        // sw, bne and wri read rd on port b
        assign b_idx = (ctrl.b_sel == cpu_pkg::b_rd) ? rd_addr : b_addr;

        // r0 is hardwired to zero on both ports
        assign a_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
        assign b_data = (b_idx == '0) ? '0 : regs[b_idx];

        always_comb begin
                case (ctrl.wb_sel)
                        cpu_pkg::wb_mem:  wb_data = mem_rdata;
                        cpu_pkg::wb_link: wb_data = link;
                        default:          wb_data = wdata;
                endcase
        end

        // write only on the retiring edge
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                                regs[i] <= '0;
                        end
                end else if (ctrl.reg_write && commit) begin
                        regs[rd_addr] <= wb_data;
                end
        end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
        input  logic [cpu_pkg::xlen-1:0]   a,
        input  logic [cpu_pkg::xlen-1:0]   b,
        input  logic [cpu_pkg::imm8_w-1:0] imm8,
        ctrl_if.user                       ctrl,
        output logic [cpu_pkg::xlen-1:0]   result
);

        logic [cpu_pkg::xlen-1:0] imm4_ext;
        logic [cpu_pkg::xlen-1:0] operand_b;

        // low nibble of imm8, sign extended
        assign imm4_ext = {{(cpu_pkg::xlen - cpu_pkg::imm4_w){imm8[cpu_pkg::imm4_w-1]}},
                           imm8[cpu_pkg::imm4_w-1:0]};

        assign operand_b = ctrl.alu_src ? imm4_ext : b;

        always_comb begin
                result = '0;
                case (ctrl.alu_op)
                        cpu_pkg::alu_add: begin
                                result = a + operand_b;
                        end
                        cpu_pkg::alu_sub: begin
                                result = a - operand_b;
                        end
                        cpu_pkg::alu_gt: begin
                                // unsigned compare, flag in bit 0
                                result[0] = (a > operand_b);
                        end
                        cpu_pkg::alu_eq: begin
                                result[0] = (a == operand_b);
                        end
                        cpu_pkg::alu_lui: begin
                                // imm8 shifted into the upper byte
                                result = {imm8, {(cpu_pkg::xlen - cpu_pkg::imm8_w){1'b0}}};
                        end
                        default: begin
                                result = '0;
                        end
                endcase
        end

endmodule

// File: verilog/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
        input  logic                       clk,
        input  logic                       rst_n,
        ctrl_if.user                       ctrl,
        input  logic [cpu_pkg::imm8_w-1:0] imm8,
        input  logic [cpu_pkg::xlen-1:0]   rs1_val,
        input  logic [cpu_pkg::xlen-1:0]   bne_taken_a,
        input  logic [cpu_pkg::xlen-1:0]   bne_taken_b,
        input  logic                       mem_ready,
        input  logic                       out_ready,
        output logic [cpu_pkg::xlen-1:0]   pc,
        output logic [cpu_pkg::xlen-1:0]   link,
        output logic                       commit,
        output logic                       mem_valid,
        output logic                       out_valid
);

        logic                     run_q;
        logic                     mem_req;
        logic                     out_req;
        logic [cpu_pkg::xlen-1:0] imm4_ext;
        logic [cpu_pkg::xlen-1:0] jal_off;
        logic [cpu_pkg::xlen-1:0] bne_off;
        logic [cpu_pkg::xlen-1:0] pc_next;

        assign imm4_ext = {{(cpu_pkg::xlen - cpu_pkg::imm4_w){imm8[cpu_pkg::imm4_w-1]}},
                           imm8[cpu_pkg::imm4_w-1:0]};
        // branch offsets count instruction words
        assign jal_off  = {{(cpu_pkg::xlen - cpu_pkg::imm8_w - 1){imm8[cpu_pkg::imm8_w-1]}},
                           imm8, 1'b0};
        assign bne_off  = {imm4_ext[cpu_pkg::xlen-2:0], 1'b0};

        assign link = pc + cpu_pkg::pc_step;

        // no request until the core runs, so valids stay low through reset
        assign mem_req   = run_q && (ctrl.mem_read || ctrl.mem_write);
        assign out_req   = run_q && ctrl.out_write;
        assign mem_valid = mem_req;
        assign out_valid = out_req;

        // retire when no handshake is pending or it completes this cycle
        assign commit = run_q && (mem_req ? mem_ready : (out_req ? out_ready : 1'b1));

        always_comb begin
                case (ctrl.pc_sel)
                        cpu_pkg::pc_jal:  pc_next = pc + jal_off;
                        cpu_pkg::pc_jalr: pc_next = rs1_val + imm4_ext;
                        cpu_pkg::pc_bne: begin
                                // taken only when the compared registers differ
                                if (bne_taken_a != bne_taken_b) begin
                                        pc_next = pc + bne_off;
                                end else begin
                                        pc_next = link;
                                end
                        end
                        default:          pc_next = link;
                endcase
        end

        // pc holds under back-pressure
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pc    <= '0;
                        run_q <= 1'b0;
                end else begin
                        run_q <= 1'b1;
                        if (commit) begin
                                pc <= pc_next;
                        end
                end
        end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
        input  logic                     clk,
        input  logic                     rst_n,
        // instruction fetch, combinational read
        output logic [cpu_pkg::xlen-1:0] imem_addr,
        input  logic [cpu_pkg::xlen-1:0] imem_data,
        // data memory, valid/ready
        output logic                     mem_valid,
        output logic                     mem_write,
        output logic [cpu_pkg::xlen-1:0] mem_addr,
        output logic [cpu_pkg::xlen-1:0] mem_wdata,
        input  logic                     mem_ready,
        input  logic [cpu_pkg::xlen-1:0] mem_rdata,
        // wri output port, valid/ready
        output logic                     out_valid,
        output logic [cpu_pkg::xlen-1:0] out_data,
        input  logic                     out_ready
);

        ctrl_if ctrl ();

        cpu_pkg::opcode_t              op;
        logic [cpu_pkg::imm8_w-1:0]    imm8;
        logic [cpu_pkg::xlen-1:0]      pc;
        logic [cpu_pkg::xlen-1:0]      link;
        logic [cpu_pkg::xlen-1:0]      a_data;
        logic [cpu_pkg::xlen-1:0]      b_data;
        logic [cpu_pkg::xlen-1:0]      alu_result;
        logic                          commit;

        assign op   = cpu_pkg::opcode_t'(imem_data[cpu_pkg::op_hi:cpu_pkg::op_lo]);
        assign imm8 = imem_data[cpu_pkg::imm8_hi:cpu_pkg::imm8_lo];

        assign imem_addr = pc;
        // load and store address is rs1 + imm4
        assign mem_addr  = alu_result;
        assign mem_write = ctrl.mem_write;
        assign mem_wdata = b_data;
        assign out_data  = b_data;

        control_decoder u_dec (
                .op   (op),
                .ctrl (ctrl)
        );

        register_file u_rf (
                .clk       (clk),
                .rst_n     (rst_n),
                .rs1_addr  (imem_data[cpu_pkg::rs1_hi:cpu_pkg::rs1_lo]),
                .rd_addr   (imem_data[cpu_pkg::rd_hi:cpu_pkg::rd_lo]),
                .b_addr    (imem_data[cpu_pkg::rs2_hi:cpu_pkg::rs2_lo]),
                .wdata     (alu_result),
                .mem_rdata (mem_rdata),
                .link      (link),
                .commit    (commit),
                .a_data    (a_data),
                .b_data    (b_data),
                .ctrl      (ctrl)
        );

        alu u_alu (
                .a      (a_data),
                .b      (b_data),
                .imm8   (imm8),
                .ctrl   (ctrl),
                .result (alu_result)
        );

        // bne compares port a (rs1) against port b (rd)
        pc_sequencer u_pcs (
                .clk         (clk),
                .rst_n       (rst_n),
                .ctrl        (ctrl),
                .imm8        (imm8),
                .rs1_val     (a_data),
                .bne_taken_a (a_data),
                .bne_taken_b (b_data),
                .mem_ready   (mem_ready),
                .out_ready   (out_ready),
                .pc          (pc),
                .link        (link),
                .commit      (commit),
                .mem_valid   (mem_valid),
                .out_valid   (out_valid)
        );

endmodule

// File: testbench/cpu_top_sva.sv
`timescale 1ns/1ps

module cpu_top_sva (
        input logic        clk,
        input logic        rst_n,
        input logic [15:0] imem_addr,
        input logic        mem_valid,
        input logic        mem_write,
        input logic [15:0] mem_addr,
        input logic [15:0] mem_wdata,
        input logic        mem_ready,
        input logic        out_valid,
        input logic [15:0] out_data,
        input logic        out_ready
);

        // a stalled memory request keeps its command, address and data
        assert property (@(posedge clk) disable iff (!rst_n)
                mem_valid && !mem_ready |=> mem_valid && $stable({mem_write, mem_addr, mem_wdata}))
                else $error("memory request dropped or changed before mem_ready");

        // same rule on the wri port
        assert property (@(posedge clk) disable iff (!rst_n)
                out_valid && !out_ready |=> out_valid && $stable(out_data))
                else $error("output request dropped or changed before out_ready");

        // once the sequencer has seen reset, no request is raised
        assert property (@(posedge clk) !rst_n ##1 !rst_n |-> !mem_valid && !out_valid)
                else $error("valid high during reset");

        // instructions are halfword aligned
        assert property (@(posedge clk) disable iff (!rst_n) imem_addr[0] == 1'b0)
                else $error("odd instruction address");

endmodule

bind cpu_top cpu_top_sva u_sva (.*);

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

        localparam int words = 256;

        logic                     clk = 1'b0;
        logic                     rst_n;
        logic [cpu_pkg::xlen-1:0] imem_addr;
        logic [cpu_pkg::xlen-1:0] imem_data;
        logic                     mem_valid;
        logic                     mem_write;
        logic [cpu_pkg::xlen-1:0] mem_addr;
        logic [cpu_pkg::xlen-1:0] mem_wdata;
        logic                     mem_ready;
        logic [cpu_pkg::xlen-1:0] mem_rdata;
        logic                     out_valid;
        logic [cpu_pkg::xlen-1:0] out_data;
        logic                     out_ready;

        // memory models, then all tests back to back sliced by start tables
        logic [15:0] imem [words];
        logic [15:0] dmem [words];
        logic [15:0] prog_words [words];
        logic [15:0] exp_words [words];
        int          prog_start [words];
        int          exp_start [words];
        int          n_tests;
        int          n_prog;
        int          n_exp;
        logic [31:0] lfsr;
        int          errors;
        int          cycles;
        int          limit;
        int          exp_base;
        int          exp_count;
        int          got;

        cpu_top uut (.*);

        always #4 clk = ~clk;

        // combinational read ports, fetch index is the halfword address
        assign imem_data = imem[imem_addr[8:1]];
        assign mem_rdata = dmem[mem_addr[7:0]];

        // fibonacci lfsr, taps 32 22 2 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic check_eq(input logic [15:0] actual, input logic [15:0] expected,
                                input string what);
                if (actual !== expected) begin
                        $display("MISMATCH at %0t: %s got %h expected %h", $time, what,
                                 actual, expected);
                        errors++;
                end
        endtask

        // one bit per ready, fresh bits every falling edge
        always @(negedge clk) begin
                lfsr = lfsr_next(lfsr);
                mem_ready = lfsr[0];
                lfsr = lfsr_next(lfsr);
                out_ready = lfsr[0];
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles > limit) begin
                        $display("timeout after %0d cycles, expected outputs never came", cycles);
                        $display("sim failed");
                        $finish;
                end else begin
                        // store lands on the transfer edge
                        if (rst_n && mem_valid && mem_ready && mem_write) begin
                                dmem[mem_addr[7:0]] = mem_wdata;
                        end
                        if (rst_n && out_valid && out_ready) begin
                                if (got < exp_count) begin
                                        check_eq(out_data, exp_words[exp_base + got], "out_data");
                                end else begin
                                        $display("extra output %h at %0t", out_data, $time);
                                        errors++;
                                end
                                got++;
                        end
                end
        end

        task automatic load_cases();
                int              fd;
                logic [8*16-1:0] tok;
                logic [8*128-1:0] line;
                logic [15:0]     val;
                bit              in_prog;
                fd = $fopen("testbench/cpu_cases.txt", "r");
                if (fd == 0) begin
                        $display("could not open testbench/cpu_cases.txt");
                        errors++;
                        return;
                end
                in_prog = 1'b1;
                tok = '0;
                while ($fscanf(fd, "%s", tok) == 1) begin
                        if (tok == "#") begin
                                void'($fgets(line, fd));
                        end else if (tok == "P" || tok == "E") begin
                                in_prog = (tok == "P");
                        end else if (tok == "T") begin
                                // next test starts where this one ended
                                n_tests++;
                                prog_start[n_tests] = n_prog;
                                exp_start[n_tests] = n_exp;
                        end else begin
                                void'($sscanf(tok, "%h", val));
                                if (in_prog) begin
                                        prog_words[n_prog] = val;
                                        n_prog++;
                                end else begin
                                        exp_words[n_exp] = val;
                                        n_exp++;
                                end
                        end
                        tok = '0;
                end
                $fclose(fd);
        endtask

        task automatic run_test(input int t);
                int test_errors;
                test_errors = errors;
                @(negedge clk);
                rst_n = 1'b0;
                // undecoded opcode 7 fill, data words carry their own address
                for (int i = 0; i < words; i++) begin
                        imem[i] = {8'h70, i[7:0]};
                        dmem[i] = {i[7:0], ~i[7:0]};
                end
                for (int i = prog_start[t]; i < prog_start[t + 1]; i++) begin
                        imem[i - prog_start[t]] = prog_words[i];
                end
                exp_base = exp_start[t];
                exp_count = exp_start[t + 1] - exp_start[t];
                got = 0;
                repeat (8) @(negedge clk);
                rst_n = 1'b1;
                while (got < exp_count) @(negedge clk);
                // the halt loop must stay quiet
                repeat (8) @(negedge clk);
                check_eq(16'(got), 16'(exp_count), "output count");
                $display("test %0d: %0d outputs, %0d errors", t, got, errors - test_errors);
        endtask

        initial begin
                rst_n = 1'b0;
                mem_ready = 1'b0;
                out_ready = 1'b0;
                lfsr = 32'h1a8c_b110;
                {errors, cycles, got, exp_base, exp_count} = '0;
                {n_tests, n_prog, n_exp} = '0;
                prog_start[0] = 0;
                exp_start[0] = 0;
                load_cases();
                limit = 64 * n_prog + 200;
                if (n_tests == 0) begin
                        $display("no tests found in the cases file");
                        errors++;
                end
                for (int t = 0; t < n_tests; t++) begin
                        run_test(t);
                end
                $display("tests %0d, errors %0d", n_tests, errors);
                if (errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

// File: filelist.f
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/control_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/pc_sequencer.sv
verilog/cpu_top.sv
testbench/cpu_top_sva.sv
testbench/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_cpu_top \
        -o tb_cpu_top
./obj_dir/tb_cpu_top 2>&1 | tee sim.log
# a run that stopped early never printed its result line
if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
        exit 1
fi

// File: testbench/cpu_cases.txt
# P program words in hex, opcode rd rs1 rs2/imm4 nibbles, run from address 0
# E expected out_data values in hex in output order, T ends a test
P 8105 820D 0312 2412 55AB 8557 C300 C400 C500 C200 6000
E 0002 0008 AB07 FFFD
T
P 8107 5280 1321 1412 3511 3612 1711 C300 C400 C500 C600 C700 6000
E 0001 0000 0001 0000 0000
T
P 8104 5212 8223 A212 830F A31F 9412 951F C400 C500 6000
E 1203 FFFF
T
P 8101 8202 B212 C100 C200 B112 C100 8303 C300 833F B03E 6000
E 0002 0001 0003 0002 0001
T
P 6103 C200 C200 C100 8207 4327 C200 C300 6000
E 0002 000C
T
P 8005 50FF C000 8103 7115 D1FF C100 FFFF C100 6000
E 0000 0003 0003
T
